//--- verilog/rvj1_defines.sv
// Shared definitions for the rvj1 RV32I execution slice
// ISA widths, major opcodes, funct encodings and ALU operations

`default_nettype none

package rvj1_defines;

  ////////////////////////////////////////////////////////////
  // ISA widths
  ////////////////////////////////////////////////////////////
  localparam int XLEN  = 32;  // Data and instruction width
  localparam int RALEN = 5;   // Register address width

  ////////////////////////////////////////////////////////////
  // Major opcodes, instr[6:0]
  ////////////////////////////////////////////////////////////
  // Only the integer compute opcodes are handled by this slice
  typedef enum logic [6:0] {
    OPCODE_OPIMM = 7'b0010011,  // Register-immediate ALU ops
    OPCODE_OP    = 7'b0110011,  // Register-register ALU ops
    OPCODE_LUI   = 7'b0110111,  // Load upper immediate
    OPCODE_AUIPC = 7'b0010111   // Add upper immediate to PC
  } opcode_e;

  ////////////////////////////////////////////////////////////
  // funct3 encodings, instr[14:12]
  ////////////////////////////////////////////////////////////
  // Same values serve OP, the I suffix is kept from the spec tables
  typedef enum logic [2:0] {
    F3_ADDI      = 3'b000,  // ADD and SUB for OP
    F3_SLLI      = 3'b001,
    F3_SLTI      = 3'b010,
    F3_SLTIU     = 3'b011,
    F3_XORI      = 3'b100,
    F3_SRLI_SRAI = 3'b101,  // Logic or arithmetic by funct7
    F3_ORI       = 3'b110,
    F3_ANDI      = 3'b111
  } f3_imm_e;

  ////////////////////////////////////////////////////////////
  // funct7 encodings, instr[31:25]
  ////////////////////////////////////////////////////////////
  typedef enum logic [6:0] {
    F7_SLLI_SRLI_ADDI = 7'b0000000,  // Plain variant
    F7_SRAI_SUB       = 7'b0100000   // Bit 30 set selects SUB or SRA
  } f7_shift_imm_e;

  ////////////////////////////////////////////////////////////
  // ALU operations
  ////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    ALU_OP_ADD  = 4'd0,
    ALU_OP_SUB  = 4'd1,
    ALU_OP_SLL  = 4'd2,
    ALU_OP_SLT  = 4'd3,  // Signed compare
    ALU_OP_SLTU = 4'd4,  // Unsigned compare
    ALU_OP_XOR  = 4'd5,
    ALU_OP_SRL  = 4'd6,
    ALU_OP_SRA  = 4'd7,  // Sign fill
    ALU_OP_OR   = 4'd8,
    ALU_OP_AND  = 4'd9
  } alu_op_e;

  // Shift amount width within an XLEN operand
  localparam int SHAMT_W = 5;

endpackage

`default_nettype wire

//--- verilog/rvj1_dec_ex_if.sv
// Decode to execute link of the rvj1 slice
// Carries the registered control word, the immediate and the PC

`default_nettype none

interface rvj1_dec_ex_if import rvj1_defines::*; ();

  logic             issued;        // One cycle strobe, new control word
  logic [RALEN-1:0] rf_addr_a;     // Source register A
  logic [RALEN-1:0] rf_addr_b;     // Source register B
  alu_op_e          alu_sel;       // Operation for the ALU
  logic             rpa_or_pc;     // Operand A from PC
  logic             rpb_or_imm;    // Operand B from immediate
  logic             alu_write_rf;  // Result goes to the register file
  logic [RALEN-1:0] alu_regdest;   // Destination register
  logic [XLEN-1:0]  immediate;     // Sign extended or upper immediate
  logic [XLEN-1:0]  pc;            // Address of the instruction

  // Decoder side
  modport dec (
    output issued, rf_addr_a, rf_addr_b, alu_sel, rpa_or_pc, rpb_or_imm,
           alu_write_rf, alu_regdest, immediate, pc
  );

  // ALU and writeback side
  modport ex (
    input issued, rf_addr_a, rf_addr_b, alu_sel, rpa_or_pc, rpb_or_imm,
          alu_write_rf, alu_regdest, immediate, pc
  );

endinterface

`default_nettype wire

//--- verilog/rvj1_dec.sv
// RV32I decoder for the rvj1 slice
// Splits the instruction into fields, builds immediates and the ALU control,
// registers the control word on accept, clears it when idle, holds on stall

`default_nettype none

module rvj1_dec import rvj1_defines::*; (
  input  logic            clk_i,
  input  logic            rstn_i,

  input  logic [XLEN-1:0] instr_i,        // Instruction word
  input  logic [XLEN-1:0] instr_pc_i,     // Its address
  input  logic            instr_valid_i,

  input  logic            stall_i,
  output logic            instr_ready_o,  // Low while stalled

  rvj1_dec_ex_if.dec      dec_o
);

  ////////////////////////////////////////////////////////////
  // Instruction fields
  ////////////////////////////////////////////////////////////
  logic [6:0]       opcode;
  logic [RALEN-1:0] rd;
  logic [RALEN-1:0] rs1;
  logic [RALEN-1:0] rs2;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [XLEN-1:0]  imm_i;  // I type, sign extended
  logic [XLEN-1:0]  imm_u;  // U type, low 12 bits zero

  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];
  assign funct7 = instr_i[31:25];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u = {instr_i[31:12], 12'b0};

  // funct3/funct7 to ALU operation
  // For OP-IMM bit 30 belongs to the immediate except on shifts
  function automatic alu_op_e f3_7_to_alu_op(input f3_imm_e       f3,
                                             input f7_shift_imm_e f7,
                                             input logic          is_reg);
    alu_op_e op;
    op = ALU_OP_ADD;
    case (f3)
      F3_ADDI:      op = (is_reg && f7 == F7_SRAI_SUB) ? ALU_OP_SUB : ALU_OP_ADD;
      F3_SLLI:      op = ALU_OP_SLL;
      F3_SLTI:      op = ALU_OP_SLT;
      F3_SLTIU:     op = ALU_OP_SLTU;
      F3_XORI:      op = ALU_OP_XOR;
      F3_SRLI_SRAI: op = (f7 == F7_SRAI_SUB) ? ALU_OP_SRA : ALU_OP_SRL;
      F3_ORI:       op = ALU_OP_OR;
      F3_ANDI:      op = ALU_OP_AND;
      default:      op = ALU_OP_ADD;
    endcase
    return op;
  endfunction

  ////////////////////////////////////////////////////////////
  // Combinational decode
  ////////////////////////////////////////////////////////////
  logic [RALEN-1:0] rf_addr_a_d;
  logic [RALEN-1:0] rf_addr_b_d;
  alu_op_e          alu_sel_d;
  logic             rpa_or_pc_d;
  logic             rpb_or_imm_d;
  logic             alu_write_rf_d;
  logic [XLEN-1:0]  immediate_d;
  logic             accept;

  always_comb begin
    // Defaults describe a no-op
    rf_addr_a_d    = '0;
    rf_addr_b_d    = '0;
    alu_sel_d      = ALU_OP_ADD;
    rpa_or_pc_d    = 1'b0;
    rpb_or_imm_d   = 1'b0;
    alu_write_rf_d = 1'b0;
    immediate_d    = '0;
    case (opcode_e'(opcode))
      OPCODE_OPIMM: begin
        rf_addr_a_d    = rs1;
        alu_sel_d      = f3_7_to_alu_op(f3_imm_e'(funct3), f7_shift_imm_e'(funct7), 1'b0);
        rpb_or_imm_d   = 1'b1;
        alu_write_rf_d = 1'b1;
        immediate_d    = imm_i;
      end
      OPCODE_OP: begin
        rf_addr_a_d    = rs1;
        rf_addr_b_d    = rs2;
        alu_sel_d      = f3_7_to_alu_op(f3_imm_e'(funct3), f7_shift_imm_e'(funct7), 1'b1);
        alu_write_rf_d = 1'b1;
      end
      OPCODE_LUI: begin  // x0 + imm, rs1 stays zero
        rpb_or_imm_d   = 1'b1;
        alu_write_rf_d = 1'b1;
        immediate_d    = imm_u;
      end
      OPCODE_AUIPC: begin
        rpa_or_pc_d    = 1'b1;
        rpb_or_imm_d   = 1'b1;
        alu_write_rf_d = 1'b1;
        immediate_d    = imm_u;
      end
      default: ;  // Unknown opcode issues as a no-op
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Handshake and control word register
  ////////////////////////////////////////////////////////////
  assign instr_ready_o = ~stall_i;
  assign accept        = instr_valid_i & instr_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      dec_o.issued       <= 1'b0;
      dec_o.rf_addr_a    <= '0;
      dec_o.rf_addr_b    <= '0;
      dec_o.alu_sel      <= ALU_OP_ADD;
      dec_o.rpa_or_pc    <= 1'b0;
      dec_o.rpb_or_imm   <= 1'b0;
      dec_o.alu_write_rf <= 1'b0;
    end else if (accept) begin
      dec_o.issued       <= 1'b1;
      dec_o.rf_addr_a    <= rf_addr_a_d;
      dec_o.rf_addr_b    <= rf_addr_b_d;
      dec_o.alu_sel      <= alu_sel_d;
      dec_o.rpa_or_pc    <= rpa_or_pc_d;
      dec_o.rpb_or_imm   <= rpb_or_imm_d;
      dec_o.alu_write_rf <= alu_write_rf_d;
    end else if (!stall_i) begin  // Idle cycle, back to no-op
      dec_o.issued       <= 1'b0;
      dec_o.rf_addr_a    <= '0;
      dec_o.rf_addr_b    <= '0;
      dec_o.alu_sel      <= ALU_OP_ADD;
      dec_o.rpa_or_pc    <= 1'b0;
      dec_o.rpb_or_imm   <= 1'b0;
      dec_o.alu_write_rf <= 1'b0;
    end
  end

  // Payload, only meaningful with alu_write_rf
  always_ff @(posedge clk_i) begin
    if (accept) begin
      dec_o.alu_regdest <= rd;
      dec_o.immediate   <= immediate_d;
      dec_o.pc          <= instr_pc_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/rvj1_alu.sv
// Execute stage of the rvj1 slice
// Picks the operands from PC, immediate or register file and runs the ALU

`default_nettype none

module rvj1_alu import rvj1_defines::*; (
  rvj1_dec_ex_if.ex        ctrl_i,

  output logic [RALEN-1:0] rf_addr_a_o,   // Register file read port A
  output logic [RALEN-1:0] rf_addr_b_o,   // Register file read port B
  input  logic [XLEN-1:0]  rf_data_a_i,
  input  logic [XLEN-1:0]  rf_data_b_i,

  output logic [XLEN-1:0]  alu_result_o
);

  logic [XLEN-1:0]    op_a;
  logic [XLEN-1:0]    op_b;
  logic [SHAMT_W-1:0] shamt;

  // Read addresses come straight from the control word
  assign rf_addr_a_o = ctrl_i.rf_addr_a;
  assign rf_addr_b_o = ctrl_i.rf_addr_b;

  ////////////////////////////////////////////////////////////
  // Operand selection
  ////////////////////////////////////////////////////////////
  assign op_a  = ctrl_i.rpa_or_pc  ? ctrl_i.pc        : rf_data_a_i;  // AUIPC uses PC
  assign op_b  = ctrl_i.rpb_or_imm ? ctrl_i.immediate : rf_data_b_i;
  assign shamt = op_b[SHAMT_W-1:0];  // Low 5 bits only

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (ctrl_i.alu_sel)
      ALU_OP_ADD:  alu_result_o = op_a + op_b;
      ALU_OP_SUB:  alu_result_o = op_a - op_b;
      ALU_OP_SLL:  alu_result_o = op_a << shamt;
      ALU_OP_SLT:  alu_result_o = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_OP_SLTU: alu_result_o = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_OP_XOR:  alu_result_o = op_a ^ op_b;
      ALU_OP_SRL:  alu_result_o = op_a >> shamt;
      ALU_OP_SRA:  alu_result_o = $unsigned($signed(op_a) >>> shamt);  // Sign fill
      ALU_OP_OR:   alu_result_o = op_a | op_b;
      ALU_OP_AND:  alu_result_o = op_a & op_b;
      default:     alu_result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/rvj1_regfile.sv
// Integer register file, 32 entries of XLEN bits
// Two combinational read ports, one write port, x0 hardwired to zero

`default_nettype none

module rvj1_regfile import rvj1_defines::*; (
  input  logic             clk_i,
  input  logic             rstn_i,

  input  logic [RALEN-1:0] raddr_a_i,
  input  logic [RALEN-1:0] raddr_b_i,
  output logic [XLEN-1:0]  rdata_a_o,
  output logic [XLEN-1:0]  rdata_b_o,

  input  logic             we_i,
  input  logic [RALEN-1:0] waddr_i,
  input  logic [XLEN-1:0]  wdata_i
);

  // x1 to x31 only, x0 has no storage
  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin  // Writes to x0 dropped
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

`default_nettype wire

//--- verilog/rvj1_wb.sv
// Writeback stage of the rvj1 slice
// Writes the ALU result into the register file and reports it at the ports

`default_nettype none

module rvj1_wb import rvj1_defines::*; (
  input  logic             clk_i,
  input  logic             rstn_i,
  input  logic             stall_i,

  rvj1_dec_ex_if.ex        ctrl_i,
  input  logic [XLEN-1:0]  alu_result_i,

  output logic             rf_we_o,     // Register file write port
  output logic [RALEN-1:0] rf_waddr_o,
  output logic [XLEN-1:0]  rf_wdata_o,

  output logic             wb_valid_o,  // Reported writeback
  output logic [RALEN-1:0] wb_rd_o,
  output logic [XLEN-1:0]  wb_data_o
);

  logic wb_fire;

  // New control word that writes a register
  assign wb_fire = ctrl_i.issued & ctrl_i.alu_write_rf;

  // Stall blocks the write, decoder holds it for later
  assign rf_we_o    = wb_fire & ~stall_i;
  assign rf_waddr_o = ctrl_i.alu_regdest;
  assign rf_wdata_o = alu_result_i;

  // One cycle strobe, held while stalled
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      wb_valid_o <= 1'b0;
    end else if (!stall_i) begin
      wb_valid_o <= wb_fire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rf_we_o) begin
      wb_rd_o   <= ctrl_i.alu_regdest;  // x0 still reported
      wb_data_o <= alu_result_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/rvj1_core.sv
// Top level of the rvj1 RV32I execution slice
// Decoder, ALU, register file and writeback stage wired together

`default_nettype none

module rvj1_core import rvj1_defines::*; (
  input  logic             clk_i,
  input  logic             rstn_i,

  // Instruction input
  input  logic [XLEN-1:0]  instr_i,
  input  logic [XLEN-1:0]  instr_pc_i,
  input  logic             instr_valid_i,

  // Flow control
  input  logic             stall_i,
  output logic             instr_ready_o,

  // Writeback report
  output logic             wb_valid_o,
  output logic [RALEN-1:0] wb_rd_o,
  output logic [XLEN-1:0]  wb_data_o
);

  ////////////////////////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////////////////////////
  rvj1_dec_ex_if dec_ex ();  // Registered control word

  logic [RALEN-1:0] rf_raddr_a;
  logic [RALEN-1:0] rf_raddr_b;
  logic [XLEN-1:0]  rf_rdata_a;
  logic [XLEN-1:0]  rf_rdata_b;
  logic [XLEN-1:0]  alu_result;
  logic             rf_we;
  logic [RALEN-1:0] rf_waddr;
  logic [XLEN-1:0]  rf_wdata;

  ////////////////////////////////////////////////////////////
  // Stages
  ////////////////////////////////////////////////////////////
  rvj1_dec u_dec (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_i       (instr_i),
    .instr_pc_i    (instr_pc_i),
    .instr_valid_i (instr_valid_i),
    .stall_i       (stall_i),
    .instr_ready_o (instr_ready_o),
    .dec_o         (dec_ex.dec)
  );

  rvj1_alu u_alu (
    .ctrl_i       (dec_ex.ex),
    .rf_addr_a_o  (rf_raddr_a),
    .rf_addr_b_o  (rf_raddr_b),
    .rf_data_a_i  (rf_rdata_a),
    .rf_data_b_i  (rf_rdata_b),
    .alu_result_o (alu_result)
  );

  rvj1_regfile u_rf (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata)
  );

  rvj1_wb u_wb (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .stall_i      (stall_i),
    .ctrl_i       (dec_ex.ex),
    .alu_result_i (alu_result),
    .rf_we_o      (rf_we),
    .rf_waddr_o   (rf_waddr),
    .rf_wdata_o   (rf_wdata),
    .wb_valid_o   (wb_valid_o),
    .wb_rd_o      (wb_rd_o),
    .wb_data_o    (wb_data_o)
  );

endmodule

`default_nettype wire

//--- test/rvj1_core_asserts.sv
// Port level assertions for the rvj1 execution slice
// Reset state of the writeback strobe, issue to writeback latency, ready
// and the writeback outputs holding across a stall

`default_nettype none

module rvj1_core_asserts import rvj1_defines::*; (
  input logic             clk_i,
  input logic             rstn_i,
  input logic [XLEN-1:0]  instr_i,
  input logic             instr_valid_i,
  input logic             stall_i,
  input logic             instr_ready_o,
  input logic             wb_valid_o,
  input logic [RALEN-1:0] wb_rd_o,
  input logic [XLEN-1:0]  wb_data_o
);

  timeunit 1ns;
  timeprecision 100ps;

  int   fail_count = 0;  // Read back by the testbench
  logic writes_rf;
  logic accept_wr;

  // Opcodes that produce a writeback
  assign writes_rf = instr_i[6:0] inside {OPCODE_OPIMM, OPCODE_OP, OPCODE_LUI, OPCODE_AUIPC};
  assign accept_wr = instr_valid_i & ~stall_i & writes_rf;

  ////////////////////////////////////////////////////////////
  // Properties
  ////////////////////////////////////////////////////////////
  reset_clears_wb: assert property (@(posedge clk_i) !rstn_i |=> !wb_valid_o)
    else begin
      fail_count++;
      $error("wb_valid_o high after a reset edge");
    end

  // Accepted at E0, no stall at E1, strobe seen after E1
  wb_after_two_edges: assert property (@(posedge clk_i) disable iff (!rstn_i)
      ($past(accept_wr, 2) && !$past(stall_i)) |-> wb_valid_o)
    else begin
      fail_count++;
      $error("wb_valid_o missing two edges after an accepted instruction");
    end

  ready_is_not_stall: assert property (@(posedge clk_i) instr_ready_o == !stall_i)
    else begin
      fail_count++;
      $error("instr_ready_o does not follow the inverse of stall_i");
    end

  // No new writeback is reported on a stalled edge
  wb_holds_on_stall: assert property (@(posedge clk_i) disable iff (!rstn_i)
      stall_i |=> $stable(wb_valid_o) && (!wb_valid_o || $stable({wb_rd_o, wb_data_o})))
    else begin
      fail_count++;
      $error("Writeback outputs changed across a stalled edge");
    end

endmodule

bind rvj1_core rvj1_core_asserts u_asserts (
  .clk_i         (clk_i),
  .rstn_i        (rstn_i),
  .instr_i       (instr_i),
  .instr_valid_i (instr_valid_i),
  .stall_i       (stall_i),
  .instr_ready_o (instr_ready_o),
  .wb_valid_o    (wb_valid_o),
  .wb_rd_o       (wb_rd_o),
  .wb_data_o     (wb_data_o)
);

`default_nettype wire

//--- test/rvj1_core_tb.sv
// Testbench for the rvj1 RV32I execution slice
// Sweeps the register file after reset, then replays the data file
// with forced and random stalls and checks every reported writeback

`default_nettype none

module rvj1_core_tb import rvj1_defines::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_LINES    = 23;  // Instructions in the data file
  localparam int WORDS        = 6;   // Fields per line
  localparam int SWEEP_REGS   = 31;  // x1 to x31
  localparam int WATCHDOG_NS  = ((NUM_LINES + SWEEP_REGS) * 20 + RESET_CYCLES) * CLK_PERIOD;

  logic             clk_i = 1'b0;
  logic             rstn_i;
  logic [XLEN-1:0]  instr_i;
  logic [XLEN-1:0]  instr_pc_i;
  logic             instr_valid_i;
  logic             stall_i;
  logic             instr_ready_o;
  logic             wb_valid_o;
  logic [RALEN-1:0] wb_rd_o;
  logic [XLEN-1:0]  wb_data_o;

  logic [XLEN-1:0]       stim [0:NUM_LINES*WORDS-1];  // Data file image
  logic [RALEN+XLEN-1:0] exp_q [$];                    // {rd, data} in issue order
  int                    errors     = 0;
  int                    compared   = 0;
  integer                seed       = 66295;
  logic                  stall_prev = 1'b0;            // Stall seen at the last edge

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  rvj1_core DUT (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_i       (instr_i),
    .instr_pc_i    (instr_pc_i),
    .instr_valid_i (instr_valid_i),
    .stall_i       (stall_i),
    .instr_ready_o (instr_ready_o),
    .wb_valid_o    (wb_valid_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  task automatic check_value(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] expected);
    if (got !== expected) begin
      errors++;
      $display("FAILED %s: got 0x%08h, expected 0x%08h at %0t", name, got, expected, $time);
    end
  endtask

  // About one cycle in eight stalled
  function automatic logic random_stall();
    return ($random(seed) & 7) == 0;
  endfunction

  // Present one instruction until the DUT takes it
  task automatic issue_instr(input logic [XLEN-1:0] instr, input logic [XLEN-1:0] pc,
                             input logic forced_stall);
    int   hold;
    logic accepted;
    hold          = forced_stall ? 2 : 0;  // Stall edges before release
    accepted      = 1'b0;
    instr_i       = instr;
    instr_pc_i    = pc;
    instr_valid_i = 1'b1;
    stall_i       = (hold > 0) || random_stall();
    while (!accepted) begin
      @(posedge clk_i);
      check_value("instr_ready_o", {{(XLEN-1){1'b0}}, instr_ready_o},
                  {{(XLEN-1){1'b0}}, ~stall_i});
      accepted = instr_ready_o;  // Valid is held high
      if (hold > 0) hold--;
      #1;
      if (!accepted) stall_i = (hold > 0) || random_stall();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Writeback monitor
  ////////////////////////////////////////////////////////////
  // Sampled mid cycle where the outputs are stable
  // A stalled edge only repeats the old strobe
  always @(negedge clk_i) begin
    logic [RALEN+XLEN-1:0] exp_wb;
    if (rstn_i && wb_valid_o && !stall_prev) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Unexpected writeback to x%0d with nothing pending at %0t", wb_rd_o, $time);
      end else begin
        exp_wb = exp_q.pop_front();
        check_value("wb_rd_o", {{(XLEN-RALEN){1'b0}}, wb_rd_o},
                    {{(XLEN-RALEN){1'b0}}, exp_wb[XLEN +: RALEN]});
        check_value("wb_data_o", wb_data_o, exp_wb[XLEN-1:0]);
        compared++;
      end
    end
    stall_prev = stall_i;
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    int wait_cycles;
    rstn_i        = 1'b0;
    instr_i       = '0;
    instr_pc_i    = '0;
    instr_valid_i = 1'b0;
    stall_i       = 1'b0;
    $readmemh("test/rvj1_core_input.txt", stim);
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rstn_i = 1'b1;

    // ADDI xr, xr, 0 on every register reads back zero
    for (int r = 1; r <= SWEEP_REGS; r++) begin
      exp_q.push_back({r[RALEN-1:0], {XLEN{1'b0}}});
      issue_instr({12'h000, r[RALEN-1:0], 3'b000, r[RALEN-1:0], OPCODE_OPIMM}, '0, 1'b0);
    end

    for (int i = 0; i < NUM_LINES; i++) begin
      if (stim[i*WORDS+3][0]) begin  // Line expects a writeback
        exp_q.push_back({stim[i*WORDS+4][RALEN-1:0], stim[i*WORDS+5]});
      end
      issue_instr(stim[i*WORDS], stim[i*WORDS+1], stim[i*WORDS+2][0]);
    end
    instr_valid_i = 1'b0;
    stall_i       = 1'b0;

    // Drain and leave room for a stray writeback
    wait_cycles = 0;
    while (exp_q.size() != 0 && wait_cycles < 20) begin
      @(posedge clk_i);
      wait_cycles++;
    end
    repeat (4) @(posedge clk_i);
    if (exp_q.size() != 0) begin
      errors += exp_q.size();
      $display("%0d expected writebacks never arrived", exp_q.size());
    end
    errors += DUT.u_asserts.fail_count;

    $display("Errors: %0d, writebacks compared: %0d, assertion failures: %0d",
             errors, compared, DUT.u_asserts.fail_count);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/rvj1_core_input.txt
// instr    pc       stall valid rd data, all hex, stall 1 holds stall_i for two edges
// data is the value expected in rd when valid is 1, registers start at zero
ffb00093 00000100 0 1 01 fffffffb  // addi x1, x0, -5
06400113 00000104 0 1 02 00000064  // addi x2, x0, 100
ffc0a193 00000108 0 1 03 00000001  // slti x3, x1, -4
fff13213 0000010c 0 1 04 00000001  // sltiu x4, x2, -1
fff0c293 00000110 0 1 05 00000004  // xori x5, x1, -1
f0016313 00000114 0 1 06 ffffff64  // ori x6, x2, -256
ff00f393 00000118 0 1 07 fffffff0  // andi x7, x1, -16
00411413 0000011c 1 1 08 00000640  // slli x8, x2, 4
01c0d493 00000120 0 1 09 0000000f  // srli x9, x1, 28
4010d513 00000124 0 1 0a fffffffd  // srai x10, x1, 1
002085b3 00000128 0 1 0b 0000005f  // add x11, x1, x2
40258633 0000012c 1 1 0c fffffffb  // sub x12, x11, x2
005626b3 00000130 0 1 0d 00000001  // slt x13, x12, x5
00563733 00000134 0 1 0e 00000000  // sltu x14, x12, x5
009357b3 00000138 0 1 0f 0001ffff  // srl x15, x6, x9
00341833 0000013c 0 1 10 00000c80  // sll x16, x8, x3
4033d8b3 00000140 0 1 11 fffffff8  // sra x17, x7, x3
abcde937 00000144 0 1 12 abcde000  // lui x18, 0xabcde
12345997 00000148 0 1 13 12345148  // auipc x19, 0x12345
00708013 0000014c 1 1 00 00000002  // addi x0, x1, 7
01200a33 00000150 0 1 14 abcde000  // add x20, x0, x18
00002083 00000154 0 0 00 00000000  // lw x1, 0(x0), unknown here
00008a93 00000158 0 1 15 fffffffb  // addi x21, x1, 0

//--- rvj1_core.f
verilog/rvj1_defines.sv
verilog/rvj1_dec_ex_if.sv
verilog/rvj1_dec.sv
verilog/rvj1_alu.sv
verilog/rvj1_regfile.sv
verilog/rvj1_wb.sv
verilog/rvj1_core.sv
test/rvj1_core_asserts.sv
test/rvj1_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the rvj1_core testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f rvj1_core.f --top-module rvj1_core_tb -Mdir "$OBJ_DIR" > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$OBJ_DIR/Vrvj1_core_tb" +verilator+error+limit+100 > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" "$SIM_LOG"; then
  exit 1
fi
if ! grep -q "Simulation finished: PASS" "$SIM_LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0
